/* filelist.f */
source/freq_meter_pkg.sv
source/wave_sync_edge.sv
source/timebase_counter.sv
source/gate_fsm.sv
source/span_capture.sv
source/freq_meter_top.sv
tests/freq_meter_props.sv
tests/freq_meter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module freq_meter_tb -f filelist.f -o freq_meter_sim > build.log 2>&1 \
    && ./obj_dir/freq_meter_sim > sim.log 2>&1 \
    || { echo "build or simulation stopped with an error"; cat build.log sim.log; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log \
    && echo "run_sim: testbench passed" \
    || { echo "run_sim: pass line missing from sim.log"; exit 1; }

/* source/freq_meter_pkg.sv */
/*
 * freq_meter_pkg
 * shared types of the square wave frequency and duty-cycle meter
 */
package freq_meter_pkg;

    // widest stamp any instance may use, sets the result field width
    localparam int MAX_STAMP_W = 32;

    // synchronized wave and its edges
    typedef struct packed {
        logic level;    // wave after the synchronizer
        logic rise;     // 0 -> 1 seen this cycle
        logic fall;     // 1 -> 0 seen this cycle
    } edge_evt_t;

    // measurement gate states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,  // waiting for start
        ARM     = 2'd1,  // waiting for the opening rise
        MEASURE = 2'd2,  // gate open, counting rises
        DONE    = 2'd3   // one cycle, result valid
    } gate_state_t;

    // gate control toward the capture block
    typedef struct packed {
        logic open;     // pulse on the opening rise
        logic close;    // pulse on the closing rise
        logic active;   // gate open, closing cycle excluded
    } gate_ctrl_t;

    // reported measurement
    typedef struct packed {
        logic [MAX_STAMP_W-1:0] period_ticks;  // span in pll_clk ticks
        logic [MAX_STAMP_W-1:0] high_ticks;    // ticks with the wave high
        logic [15:0]            cycles;        // rising edges spanned
    } meas_result_t;

endpackage

/* source/freq_meter_top.sv */
`timescale 1ns/1ps
/*
 * freq_meter_top
 * frequency and duty-cycle meter for one square wave on pll_clk
 */
module freq_meter_top #(
    parameter int STAMP_W = 32,  // timestamp and tick count width
    parameter int CYCLE_W = 16   // n_cycles width
) (
    input  logic                         pll_clk,
    input  logic                         sys_rst_n,
    input  logic                         wave_in,
    input  logic                         start,
    input  logic [CYCLE_W-1:0]           n_cycles,
    output logic                         busy,
    output logic                         done,
    output freq_meter_pkg::meas_result_t result
);

    freq_meter_pkg::edge_evt_t  evt;       // synchronized wave events
    freq_meter_pkg::gate_ctrl_t gate;      // open / close / active
    logic [STAMP_W-1:0]         stamp;
    logic [15:0]                cycles;    // latched target

    wave_sync_edge i_wave_sync_edge (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave_in   (wave_in),
        .evt       (evt)
    );

    timebase_counter #(.STAMP_W(STAMP_W)) i_timebase_counter (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .stamp     (stamp)
    );

    gate_fsm #(.CYCLE_W(CYCLE_W)) i_gate_fsm (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .n_cycles  (n_cycles),
        .evt       (evt),
        .gate      (gate),
        .busy      (busy),
        .done      (done),
        .cycles    (cycles)
    );

    span_capture #(.STAMP_W(STAMP_W)) i_span_capture (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .evt       (evt),
        .gate      (gate),
        .stamp     (stamp),
        .cycles    (cycles),
        .result    (result)
    );

endmodule

/* source/gate_fsm.sv */
`timescale 1ns/1ps
/*
 * gate_fsm
 * arms on start, opens the gate on the next rising edge of the wave and
 * closes it after the requested number of further rising edges
 */
module gate_fsm #(
    parameter int CYCLE_W = 16
) (
    input  logic                       pll_clk,
    input  logic                       sys_rst_n,
    input  logic                       start,      // one-cycle strobe
    input  logic [CYCLE_W-1:0]         n_cycles,   // held stable while busy
    input  freq_meter_pkg::edge_evt_t  evt,
    output freq_meter_pkg::gate_ctrl_t gate,
    output logic                       busy,
    output logic                       done,
    output logic [15:0]                cycles      // latched target
);

    freq_meter_pkg::gate_state_t state;
    freq_meter_pkg::gate_state_t state_nxt;

    logic [CYCLE_W-1:0] rise_cnt;   // rises since the gate opened
    logic [CYCLE_W-1:0] target;     // n_cycles captured at start
    logic               accept;     // start taken this cycle
    logic               last_rise;  // next rise completes the count

    assign accept    = (state == freq_meter_pkg::IDLE) && start && (n_cycles != '0);
    assign last_rise = (rise_cnt + CYCLE_W'(1)) == target;

    // gate decode straight from state and edge
    always_comb begin
        gate.open   = (state == freq_meter_pkg::ARM) && evt.rise;
        gate.close  = (state == freq_meter_pkg::MEASURE) && evt.rise && last_rise;
        gate.active = (state == freq_meter_pkg::MEASURE) && !gate.close;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            freq_meter_pkg::IDLE:    if (accept) state_nxt = freq_meter_pkg::ARM;
            freq_meter_pkg::ARM:     if (gate.open) state_nxt = freq_meter_pkg::MEASURE;
            freq_meter_pkg::MEASURE: if (gate.close) state_nxt = freq_meter_pkg::DONE;
            default:                 state_nxt = freq_meter_pkg::IDLE;  // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= freq_meter_pkg::IDLE;
            rise_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (gate.open) begin
                rise_cnt <= '0;                      // opening rise is not counted
            end else if (gate.active && evt.rise) begin
                rise_cnt <= rise_cnt + CYCLE_W'(1);
            end
        end
    end

    // target only changes on an accepted start
    always_ff @(posedge pll_clk) begin
        if (accept) begin
            target <= n_cycles;
        end
    end

    assign busy   = (state == freq_meter_pkg::ARM) || (state == freq_meter_pkg::MEASURE);
    assign done   = (state == freq_meter_pkg::DONE);  // one cycle after close
    assign cycles = 16'(target);

endmodule

/* source/span_capture.sv */
`timescale 1ns/1ps
/*
 * span_capture
 * stamps the opening edge, counts high ticks while the gate is open and
 * forms period, high time and cycle count on the closing edge
 */
module span_capture #(
    parameter int STAMP_W = 32
) (
    input  logic                         pll_clk,
    input  logic                         sys_rst_n,
    input  freq_meter_pkg::edge_evt_t    evt,
    input  freq_meter_pkg::gate_ctrl_t   gate,
    input  logic [STAMP_W-1:0]           stamp,    // free-running time
    input  logic [15:0]                  cycles,   // target from the FSM
    output freq_meter_pkg::meas_result_t result
);

    localparam int RES_W = freq_meter_pkg::MAX_STAMP_W;

    logic [STAMP_W-1:0] start_stamp;  // time of the opening rise
    logic [STAMP_W-1:0] high_cnt;     // high ticks so far
    logic [STAMP_W-1:0] span;         // end minus start
    logic [STAMP_W-1:0] high_total;   // high count incl. closing cycle

    // modular difference, counter wrap falls out for free
    assign span = stamp - start_stamp;

    // open cycle is skipped by active, the closing cycle stands in for it
    // since level is high on both rises
    assign high_total = high_cnt + STAMP_W'(evt.level);

    always_ff @(posedge pll_clk) begin
        if (gate.open) begin
            start_stamp <= stamp;
            high_cnt    <= '0;
        end else if (gate.active && evt.level) begin
            high_cnt <= high_cnt + STAMP_W'(1);
        end
    end

    // result held until the next closing edge overwrites it
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            result <= '0;
        end else if (gate.close) begin
            result.period_ticks <= RES_W'(span);       // zero-extended
            result.high_ticks   <= RES_W'(high_total);
            result.cycles       <= cycles;
        end
    end

endmodule

/* source/timebase_counter.sv */
`timescale 1ns/1ps
/*
 * timebase_counter
 * free-running timestamp, wraps modulo 2**STAMP_W
 */
module timebase_counter #(
    parameter int STAMP_W = 32
) (
    input  logic               pll_clk,
    input  logic               sys_rst_n,
    output logic [STAMP_W-1:0] stamp     // common time reference
);

    // never stops or reloads, both edges of a span read the same clock
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            stamp <= '0;
        end else begin
            stamp <= stamp + STAMP_W'(1);  // rolls over silently
        end
    end

endmodule

/* source/wave_sync_edge.sv */
`timescale 1ns/1ps
/*
 * wave_sync_edge
 * brings the asynchronous wave into pll_clk and flags its edges
 */
module wave_sync_edge (
    input  logic                      pll_clk,
    input  logic                      sys_rst_n,
    input  logic                      wave_in,   // asynchronous square wave
    output freq_meter_pkg::edge_evt_t evt
);

    logic sync_q1;   // first stage, may go metastable
    logic sync_q2;   // settled level
    logic prev_q;    // level one cycle back

    // two-stage synchronizer plus history bit
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            prev_q  <= 1'b0;
        end else begin
            sync_q1 <= wave_in;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // same path length for both edges, so spans stay exact
    always_comb begin
        evt.level = sync_q2;
        evt.rise  = sync_q2 & ~prev_q;  // low last cycle, high now
        evt.fall  = ~sync_q2 & prev_q;  // high last cycle, low now
    end

endmodule

/* tests/freq_meter_props.sv */
`timescale 1ns/1ps
/*
 * freq_meter_props
 * protocol checks on the gate FSM and the capture block, attached by bind
 */
module freq_meter_props #(
    parameter bit FSM_SIDE = 1'b1  // 1 on gate_fsm, 0 on span_capture
) (
    input logic                         pll_clk,
    input logic                         sys_rst_n,
    input freq_meter_pkg::gate_ctrl_t   gate,
    input freq_meter_pkg::gate_state_t  state,
    input logic                         busy,
    input logic                         done,
    input freq_meter_pkg::meas_result_t result
);

    int fail_cnt = 0;  // read by the testbench

    if (FSM_SIDE) begin : g_fsm
        // done never lasts two cycles
        done_one_cycle: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            done |=> !done)
            else begin
                fail_cnt++;
                $error("done held high for more than one cycle");
            end

        // close is always answered by done one cycle later
        done_after_close: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            gate.close |=> done)
            else begin
                fail_cnt++;
                $error("close not followed by done");
            end

        // nothing runs in IDLE
        idle_quiet: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            (state == freq_meter_pkg::IDLE) |-> (!busy && !gate.active))
            else begin
                fail_cnt++;
                $error("busy or active high in IDLE");
            end
    end else begin : g_cap
        // result registered on close, so check it in the done cycle
        high_within_span: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
            gate.close |=> (result.high_ticks <= result.period_ticks))
            else begin
                fail_cnt++;
                $error("high_ticks larger than period_ticks");
            end
    end

endmodule

bind gate_fsm freq_meter_props #(.FSM_SIDE(1'b1)) i_fsm_props (
    .pll_clk(pll_clk), .sys_rst_n(sys_rst_n), .gate(gate), .state(state),
    .busy(busy), .done(done), .result('0)
);

bind span_capture freq_meter_props #(.FSM_SIDE(1'b0)) i_cap_props (
    .pll_clk(pll_clk), .sys_rst_n(sys_rst_n), .gate(gate), .state(freq_meter_pkg::IDLE),
    .busy(1'b0), .done(1'b0), .result(result)
);

/* tests/freq_meter_tb.sv */
`timescale 1ns/1ps
/*
 * freq_meter_tb
 * directed and seeded random tests of the frequency and duty-cycle meter
 */
module freq_meter_tb;

    localparam int STAMP_W   = 16;   // small stamp, wraps every 65536 cycles
    localparam int CYCLE_W   = 16;
    localparam int CLK_HALF  = 50;   // 100 ns period
    localparam int STAMP_MOD = 1 << STAMP_W;
    localparam int RAND_RUNS = 6;
    localparam int MAX_P     = 20;
    localparam int MAX_N     = 8;
    localparam int WRAP_P    = 37;
    localparam int WRAP_N    = 8;

    // sum of N*P over all tests, the wait for the stamp wrap, plus margin
    localparam int WATCHDOG_CYCLES = 4 * 10 + RAND_RUNS * MAX_N * MAX_P
                                   + WRAP_N * WRAP_P + 4 * 10 + STAMP_MOD + 5000;

    logic                         pll_clk;
    logic                         sys_rst_n;
    logic                         wave_in;
    logic                         start;
    logic [CYCLE_W-1:0]           n_cycles;
    logic                         busy;
    logic                         done;
    freq_meter_pkg::meas_result_t result;

    logic [31:0] rng_state;       // xorshift state
    int          cyc = 0;         // cycles since reset release, follows the stamp
    int          done_count = 0;  // done pulses seen so far

    freq_meter_top #(.STAMP_W(STAMP_W), .CYCLE_W(CYCLE_W)) i_freq_meter_top (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave_in   (wave_in),
        .start     (start),
        .n_cycles  (n_cycles),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    always #(CLK_HALF) pll_clk = ~pll_clk;

    always @(posedge pll_clk) begin
        if (sys_rst_n) cyc <= cyc + 1;
    end

    always @(negedge pll_clk) begin
        if (sys_rst_n && done) done_count <= done_count + 1;  // mid-cycle, stable
    end

    task automatic stop_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_result(input freq_meter_pkg::meas_result_t got,
                                input freq_meter_pkg::meas_result_t exp, input string what);
        if (got !== exp) begin
            stop_fail($sformatf("FAIL @ %0t: %s got period %0d high %0d cycles %0d, %s",
                $time, what, got.period_ticks, got.high_ticks, got.cycles,
                $sformatf("expected %0d %0d %0d", exp.period_ticks, exp.high_ticks,
                exp.cycles)));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_fail($sformatf("FAIL @ %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_fail($sformatf("FAIL @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // uniform-ish draw in [lo, hi]
    task automatic draw(input int lo, input int hi, output int val);
        rng_state = xorshift(rng_state);
        val = lo + int'(rng_state % 32'(hi - lo + 1));
    endtask

    // span and high time are whole periods of the wave, counted modulo the stamp
    function automatic freq_meter_pkg::meas_result_t expect_result(input int p, input int h,
                                                                   input int n);
        freq_meter_pkg::meas_result_t r;
        r.period_ticks = 32'((n * p) % STAMP_MOD);
        r.high_ticks   = 32'((n * h) % STAMP_MOD);
        r.cycles       = 16'(n);
        return r;
    endfunction

    // wave synchronous to pll_clk, each period starts with its high phase
    task automatic drive_wave(input int p, input int h, input int periods);
        repeat (periods) begin
            for (int i = 0; i < p; i++) begin
                @(posedge pll_clk);
                wave_in <= (i < h);
            end
        end
        @(posedge pll_clk);
        wave_in <= 1'b0;  // park low between tests
    endtask

    task automatic pulse_start(input int delay);
        repeat (delay) @(posedge pll_clk);
        start <= 1'b1;
        @(posedge pll_clk);
        start <= 1'b0;
    endtask

    // busy must stay high on every cycle before done
    task automatic wait_done(input int limit, input string what);
        int waited;
        waited = 0;
        while (done !== 1'b1) begin
            check_flag(busy, 1'b1, {what, " busy before done"});
            if (waited == limit) begin
                stop_fail($sformatf("timeout: %s saw no done within %0d cycles", what, limit));
            end
            @(negedge pll_clk);
            waited++;
        end
    endtask

    // one measurement, extra > 0 adds a second start that must be ignored
    task automatic run_measure(input int p, input int h, input int n, input int extra,
                               input string what);
        freq_meter_pkg::meas_result_t exp;
        int done_before;
        exp = expect_result(p, h, n);
        @(posedge pll_clk);
        n_cycles <= CYCLE_W'(n);
        done_before = done_count;
        fork
            drive_wave(p, h, n + 2);  // opening rise plus n more
            pulse_start(0);
            if (extra > 0) pulse_start(extra);
            begin
                repeat (2) @(negedge pll_clk);  // start taken, FSM armed
                wait_done((n + 3) * p + 20, what);
                check_flag(busy, 1'b0, {what, " busy at done"});
                check_result(result, exp, {what, " at done"});
            end
        join
        check_count(done_count - done_before, 1, {what, " done pulses"});
        check_result(result, exp, {what, " after done"});
    endtask

    task automatic test_reset_state();
        freq_meter_pkg::meas_result_t zero;
        zero = '0;
        @(negedge pll_clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_result(result, zero, "result after reset");
    endtask

    task automatic test_fixed_wave();
        run_measure(10, 3, 4, 0, "fixed wave");  // 40 / 12 / 4
    endtask

    task automatic test_random_waves();
        int p;
        int h;
        int n;
        for (int run = 0; run < RAND_RUNS; run++) begin
            draw(4, MAX_P, p);
            draw(1, p - 1, h);  // at least one low tick
            draw(1, MAX_N, n);
            run_measure(p, h, n, 0, $sformatf("random run %0d", run));
        end
    endtask

    task automatic test_stamp_wrap();
        // line the gate up a little before the 16-bit rollover
        while ((cyc % STAMP_MOD) != STAMP_MOD - 150) @(negedge pll_clk);
        run_measure(WRAP_P, 11, WRAP_N, 0, "stamp wrap");
        if ((cyc % STAMP_MOD) > 2000) begin
            stop_fail("stamp wrap test finished without crossing the stamp rollover");
        end
    endtask

    task automatic test_ignored_starts();
        int done_before;
        @(posedge pll_clk);
        n_cycles <= '0;
        done_before = done_count;
        fork
            drive_wave(6, 2, 4);  // edges present, gate must stay shut
            begin
                pulse_start(0);
                repeat (20) begin
                    @(negedge pll_clk);
                    check_flag(busy, 1'b0, "busy after start with zero cycles");
                end
            end
        join
        check_count(done_count - done_before, 0, "done pulses for zero cycles");
        run_measure(10, 4, 4, 25, "second start while busy");
    endtask

    task automatic test_result_hold();
        freq_meter_pkg::meas_result_t held;
        int done_before;
        held = expect_result(10, 4, 4);  // last measurement
        done_before = done_count;
        fork
            drive_wave(8, 3, 20);  // wave runs but nobody starts
            repeat (170) begin
                @(negedge pll_clk);
                check_result(result, held, "held result");
                check_flag(busy, 1'b0, "busy while idle");
            end
        join
        check_count(done_count - done_before, 0, "done pulses while idle");
    endtask

    function automatic int prop_fails();
        return i_freq_meter_top.i_gate_fsm.i_fsm_props.fail_cnt
             + i_freq_meter_top.i_span_capture.i_cap_props.fail_cnt;
    endfunction

    // bound assertions end the run at the next falling edge
    always @(negedge pll_clk) begin
        if (prop_fails() != 0) begin
            stop_fail($sformatf("bound assertion failed, %0d failures counted", prop_fails()));
        end
    end

    initial begin
        pll_clk   = 1'b0;
        sys_rst_n = 1'b0;
        wave_in   = 1'b0;
        start     = 1'b0;
        n_cycles  = '0;
        rng_state = 32'd91;
        repeat (16) @(posedge pll_clk);
        sys_rst_n <= 1'b1;
        test_reset_state();
        test_fixed_wave();
        test_random_waves();
        test_stamp_wrap();
        test_ignored_starts();
        test_result_hold();
        repeat (4) @(posedge pll_clk);
        if (prop_fails() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_fail($sformatf("bound assertions failed %0d times", prop_fails()));
        end
    end

    // hard stop in case a wait above never returns
    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        stop_fail("watchdog expired before the tests finished");
    end

endmodule
